// File: logic/video_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared raster constants, widths and the fetch state encoding for the
// character video block. Modules refer to it by scoped names.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package video_pkg;

    // Raster geometry, in pixels and lines
    localparam int HTOTAL   = 384;
    localparam int HVISIBLE = 256;
    localparam int VTOTAL   = 264;
    localparam int VVISIBLE = 224;

    // Tiles are 8x8, one ROM word per tile row
    localparam int TILE_W    = 8;
    localparam int LINE_COLS = HTOTAL / TILE_W;

    // Column strobes seen during vertical blanking, and the first one
    // of the last blank line, where line 0 gets preloaded
    localparam int BLANK_COLS  = (VTOTAL - VVISIBLE) * LINE_COLS;
    localparam int PRELOAD_COL = BLANK_COLS - LINE_COLS;

    // Longest graphics ROM answer, in pixel periods
    localparam int ROM_WAIT_MAX = 5;

    typedef logic [8:0]  hcnt_t;
    typedef logic [8:0]  vcnt_t;
    typedef logic [9:0]  vram_addr_t;   // row * 32 + column
    typedef logic [9:0]  tile_code_t;
    typedef logic [3:0]  pal_idx_t;
    typedef logic [5:0]  char_pxl_t;    // {palette group, colour}
    typedef logic [12:0] rom_addr_t;    // {tile code, row in tile}
    typedef logic [15:0] rom_word_t;    // 8 pixels x 2 bits
    typedef logic [3:0]  rgb4_t;

    typedef enum logic [2:0] {
        IDLE,
        MAP_RD,
        ROM_RD,
        ROM_WAIT,
        HOLD
    } fetch_state_t;

endpackage

// File: logic/fetch_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch control between the tile fetch FSM and the character layer.
// The FSM sequences the strobes, the layer returns the ROM ok level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

interface fetch_if;

    logic map_rd;       // one clock, latch the video RAM word
    logic rom_cs;       // request held until ok
    logic rom_ok;
    logic data_latch;   // one clock, ROM word is valid
    logic shift_load;   // column boundary, move word into shifter

    modport fsm (
        output map_rd, rom_cs, data_latch, shift_load,
        input  rom_ok
    );

    modport layer (
        input  map_rd, rom_cs, data_latch, shift_load,
        output rom_ok
    );

endinterface

// File: logic/video_timing.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raster counters for a 384x264 frame with a 256x224 visible window.
// Gives blanking levels and the strobe that opens each 8-pixel column.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module video_timing (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen6,
    output video_pkg::hcnt_t  hdump,
    output video_pkg::vcnt_t  vdump,
    output logic              lhbl,
    output logic              lvbl,
    output logic              col_start
);

    logic line_end;
    logic frame_end;

    assign line_end  = hdump == video_pkg::hcnt_t'(video_pkg::HTOTAL - 1);
    assign frame_end = vdump == video_pkg::vcnt_t'(video_pkg::VTOTAL - 1);

    // Start on the last blank line so that the fetch preloads line 0
    // and both blanks stay low until the first frame begins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump <= video_pkg::hcnt_t'(video_pkg::HVISIBLE);
            vdump <= video_pkg::vcnt_t'(video_pkg::VTOTAL - 1);
        end else if (cen6) begin
            if (line_end) begin
                hdump <= '0;
                if (frame_end) begin
                    vdump <= '0;
                end else begin
                    vdump <= vdump + 1'b1;
                end
            end else begin
                hdump <= hdump + 1'b1;
            end
        end
    end

    // Active high while inside the visible window
    assign lhbl = hdump < video_pkg::hcnt_t'(video_pkg::HVISIBLE);
    assign lvbl = vdump < video_pkg::vcnt_t'(video_pkg::VVISIBLE);

    // One clock wide, only on the pixel enable
    assign col_start = cen6 && (hdump[2:0] == 3'd0);

endmodule

// File: logic/char_fetch_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-column fetch sequencer. Each column strobe reads the tile map, then
// the graphics ROM, and the word is handed to the shifter one column later.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module char_fetch_fsm (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cen6,
    input  logic  col_start,
    input  logic  lvbl,
    fetch_if.fsm  fetch
);

    video_pkg::fetch_state_t state;
    video_pkg::fetch_state_t state_nxt;

    logic [$clog2(video_pkg::BLANK_COLS)-1:0]     blank_cnt;
    logic [$clog2(video_pkg::ROM_WAIT_MAX+2)-1:0] wait_cnt;
    logic                                         fetch_en;

    // Column strobes counted through vertical blanking. Only the last
    // blank line fetches. Reset lands on that line.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blank_cnt <= ($bits(blank_cnt))'(video_pkg::PRELOAD_COL);
        end else if (lvbl) begin
            blank_cnt <= '0;
        end else if (col_start) begin
            blank_cnt <= blank_cnt + 1'b1;
        end
    end

    assign fetch_en = lvbl || (blank_cnt >= ($bits(blank_cnt))'(video_pkg::PRELOAD_COL));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= video_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            video_pkg::IDLE: begin
                if (col_start && fetch_en) begin
                    state_nxt = video_pkg::MAP_RD;
                end
            end
            video_pkg::MAP_RD: state_nxt = video_pkg::ROM_RD;
            // ok may still be high from the last word here, so it is ignored
            video_pkg::ROM_RD: state_nxt = video_pkg::ROM_WAIT;
            video_pkg::ROM_WAIT: begin
                if (fetch.rom_ok) begin
                    state_nxt = video_pkg::HOLD;
                end
            end
            video_pkg::HOLD: begin
                if (col_start) begin
                    state_nxt = fetch_en ? video_pkg::MAP_RD : video_pkg::IDLE;
                end
            end
            default: state_nxt = video_pkg::IDLE;
        endcase
    end

    assign fetch.map_rd     = state == video_pkg::MAP_RD;
    assign fetch.rom_cs     = (state == video_pkg::ROM_RD) || (state == video_pkg::ROM_WAIT);
    assign fetch.data_latch = (state == video_pkg::ROM_WAIT) && fetch.rom_ok;
    assign fetch.shift_load = (state == video_pkg::HOLD) && col_start;

    // Pixel periods spent waiting on the ROM, saturates one past the limit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (state != video_pkg::ROM_WAIT) begin
            wait_cnt <= '0;
        end else if (cen6 && wait_cnt <= ($bits(wait_cnt))'(video_pkg::ROM_WAIT_MAX)) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    a_rom_wait_max : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == video_pkg::ROM_WAIT) |->
            (wait_cnt <= ($bits(wait_cnt))'(video_pkg::ROM_WAIT_MAX))
    ) else $error("char ROM answer later than %0d pixels", video_pkg::ROM_WAIT_MAX);

endmodule

// File: logic/char_layer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Character layer. Holds the 32x32 tile map, builds the graphics ROM
// address one column ahead of the beam and shifts out 2-bit pixels.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module char_layer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cen6,
    input  video_pkg::hcnt_t       hdump,
    input  video_pkg::vcnt_t       vdump,
    input  logic                   flip,
    // CPU
    input  logic                   cpu_cen,
    input  logic                   vram_cs,
    input  logic                   wr_n,
    input  logic [1:0]             dseln,
    input  video_pkg::vram_addr_t  cpu_addr,
    input  logic [15:0]            cpu_dout,
    // Fetch control
    fetch_if.layer                 fetch,
    // Graphics ROM
    output logic                   char_cs,
    output video_pkg::rom_addr_t   char_addr,
    input  logic                   char_ok,
    input  video_pkg::rom_word_t   char_data,
    output video_pkg::char_pxl_t   char_pxl
);

    logic [15:0] vram [0:1023];
    logic [15:0] vram_q;

    logic [9:0]             hnext;
    logic                   hwrap;
    logic [4:0]             hcol;
    video_pkg::hcnt_t       hsrc;
    video_pkg::vcnt_t       vnext;
    video_pkg::vcnt_t       vsrc;
    video_pkg::vram_addr_t  map_idx;

    video_pkg::tile_code_t  code_q;
    video_pkg::pal_idx_t    pal_fetch;
    video_pkg::pal_idx_t    pal_q;
    logic [2:0]             row_q;
    video_pkg::rom_word_t   rom_q;
    video_pkg::rom_word_t   shreg;
    logic                   hflip_q;

    // Look-ahead position, one column past the beam. The column after
    // the end of a line belongs to the next line.
    assign hnext = {1'b0, hdump} + 10'(video_pkg::TILE_W);
    assign hwrap = hnext >= 10'(video_pkg::HTOTAL);
    assign hsrc  = hwrap ? video_pkg::hcnt_t'(hnext - 10'(video_pkg::HTOTAL)) : hnext[8:0];

    always_comb begin
        if (!hwrap) begin
            vnext = vdump;
        end else if (vdump == video_pkg::vcnt_t'(video_pkg::VTOTAL - 1)) begin
            vnext = '0;
        end else begin
            vnext = vdump + 1'b1;
        end
    end

    // Flip mirrors around the visible window on both axes
    assign vsrc    = flip ? video_pkg::vcnt_t'(video_pkg::VVISIBLE - 1) - vnext : vnext;
    assign hcol    = flip ? ~hsrc[7:3] : hsrc[7:3];
    assign map_idx = {vsrc[7:3], hcol};

    // Byte lanes, dseln[1] for the upper half
    always_ff @(posedge clk) begin
        if (cpu_cen && vram_cs && !wr_n) begin
            if (!dseln[1]) begin
                vram[cpu_addr][15:8] <= cpu_dout[15:8];
            end
            if (!dseln[0]) begin
                vram[cpu_addr][7:0] <= cpu_dout[7:0];
            end
        end
        vram_q <= vram[map_idx];
    end

    always_ff @(posedge clk) begin
        if (fetch.map_rd) begin
            code_q    <= vram_q[9:0];
            pal_fetch <= vram_q[13:10];
            row_q     <= vsrc[2:0];
        end
        if (fetch.data_latch) begin
            rom_q <= char_data;
        end
        // Load on the column boundary, otherwise one pixel per cen6
        if (fetch.shift_load) begin
            shreg <= rom_q;
            pal_q <= pal_fetch;
        end else if (cen6) begin
            shreg <= hflip_q ? shreg >> 2 : shreg << 2;
        end
    end

    // Shift direction follows the flip seen at load time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hflip_q <= 1'b0;
        end else if (fetch.shift_load) begin
            hflip_q <= flip;
        end
    end

    assign fetch.rom_ok = char_ok;
    assign char_cs      = fetch.rom_cs;
    assign char_addr    = {code_q, row_q};
    assign char_pxl     = {pal_q, hflip_q ? shreg[1:0] : shreg[15:14]};

    a_latch_in_request : assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch.data_latch |-> (fetch.rom_cs && char_ok)
    ) else $error("ROM data latched outside a request");

    a_addr_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        (fetch.rom_cs && !fetch.data_latch) |=> $stable(char_addr)
    ) else $error("char_addr moved while char_cs was high");

endmodule

// File: logic/color_mix.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Colour output stage. Looks up the 64-entry CPU palette, forces black
// while blanking and delays both blanks to line up with the colour.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module color_mix (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cen6,
    input  video_pkg::char_pxl_t  char_pxl,
    input  logic                  lhbl,
    input  logic                  lvbl,
    // CPU
    input  logic                  cpu_cen,
    input  logic                  pal_cs,
    input  logic                  wr_n,
    input  logic [5:0]            cpu_addr,
    input  logic [11:0]           cpu_dout,
    // Pixel output
    output video_pkg::rgb4_t      red,
    output video_pkg::rgb4_t      green,
    output video_pkg::rgb4_t      blue,
    output logic                  lhbl_dly,
    output logic                  lvbl_dly
);

    logic [11:0] pal_ram [0:63];
    logic [11:0] pal_rgb;
    logic        lhbl_d1;
    logic        lvbl_d1;

    // Entry layout is R, G, B from the top nibble down
    always_ff @(posedge clk) begin
        if (cpu_cen && pal_cs && !wr_n) begin
            pal_ram[cpu_addr] <= cpu_dout;
        end
    end

    assign pal_rgb = pal_ram[char_pxl];

    // The layer pixel trails the counters by one cen6, so the blanks
    // take two stages against one for the colour
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_d1  <= 1'b0;
            lvbl_d1  <= 1'b0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (cen6) begin
            lhbl_d1  <= lhbl;
            lvbl_d1  <= lvbl;
            lhbl_dly <= lhbl_d1;
            lvbl_dly <= lvbl_d1;
            if (lhbl_d1 && lvbl_d1) begin
                red   <= pal_rgb[11:8];
                green <= pal_rgb[7:4];
                blue  <= pal_rgb[3:0];
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

// File: logic/video_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Character video subsystem top. CPU writes the tile map and palette,
// the external ROM supplies tile graphics, RGB leaves with delayed blanks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module video_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cen6,
    input  logic                   flip,
    // CPU bus
    input  logic                   cpu_cen,
    input  logic                   vram_cs,
    input  logic                   pal_cs,
    input  logic                   wr_n,
    input  logic [1:0]             dseln,
    input  video_pkg::vram_addr_t  cpu_addr,
    input  logic [15:0]            cpu_dout,
    // Character graphics ROM
    output logic                   char_cs,
    output video_pkg::rom_addr_t   char_addr,
    input  logic                   char_ok,
    input  video_pkg::rom_word_t   char_data,
    // Pixel output
    output video_pkg::rgb4_t       red,
    output video_pkg::rgb4_t       green,
    output video_pkg::rgb4_t       blue,
    output logic                   lhbl_dly,
    output logic                   lvbl_dly
);

    video_pkg::hcnt_t      hdump;
    video_pkg::vcnt_t      vdump;
    logic                  lhbl;
    logic                  lvbl;
    logic                  col_start;
    video_pkg::char_pxl_t  char_pxl;

    fetch_if fetch_bus ();

    video_timing u_timing (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cen6       ( cen6       ),
        .hdump      ( hdump      ),
        .vdump      ( vdump      ),
        .lhbl       ( lhbl       ),
        .lvbl       ( lvbl       ),
        .col_start  ( col_start  )
    );

    char_fetch_fsm u_fetch (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cen6       ( cen6       ),
        .col_start  ( col_start  ),
        .lvbl       ( lvbl       ),
        .fetch      ( fetch_bus  )
    );

    char_layer u_char (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cen6       ( cen6       ),
        .hdump      ( hdump      ),
        .vdump      ( vdump      ),
        .flip       ( flip       ),
        .cpu_cen    ( cpu_cen    ),
        .vram_cs    ( vram_cs    ),
        .wr_n       ( wr_n       ),
        .dseln      ( dseln      ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_dout   ( cpu_dout   ),
        .fetch      ( fetch_bus  ),
        .char_cs    ( char_cs    ),
        .char_addr  ( char_addr  ),
        .char_ok    ( char_ok    ),
        .char_data  ( char_data  ),
        .char_pxl   ( char_pxl   )
    );

    // Palette sits on the low address and data bits
    color_mix u_colmix (
        .clk        ( clk             ),
        .rst_n      ( rst_n           ),
        .cen6       ( cen6            ),
        .char_pxl   ( char_pxl        ),
        .lhbl       ( lhbl            ),
        .lvbl       ( lvbl            ),
        .cpu_cen    ( cpu_cen         ),
        .pal_cs     ( pal_cs          ),
        .wr_n       ( wr_n            ),
        .cpu_addr   ( cpu_addr[5:0]   ),
        .cpu_dout   ( cpu_dout[11:0]  ),
        .red        ( red             ),
        .green      ( green           ),
        .blue       ( blue            ),
        .lhbl_dly   ( lhbl_dly        ),
        .lvbl_dly   ( lvbl_dly        )
    );

endmodule

// File: dv/video_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Watches the video outputs, tracks the screen position and compares the
// colour at queued positions. Also checks blanking shape and black level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module video_checker (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen6,
    input  video_pkg::rgb4_t  red,
    input  video_pkg::rgb4_t  green,
    input  video_pkg::rgb4_t  blue,
    input  logic              lhbl_dly,
    input  logic              lvbl_dly,
    input  logic              exp_valid,
    input  logic [8:0]        exp_x,
    input  logic [8:0]        exp_y,
    input  logic [11:0]       exp_rgb,
    input  logic              exp_flush,
    output int                value_errs,
    output int                timing_errs,
    output int                miss_errs
);

    int          q_x[$];
    int          q_y[$];
    logic [11:0] q_rgb[$];
    int          col;
    int          line;
    logic        prev_h;
    logic        prev_v;
    logic        in_frame;
    logic        pre_frame;
    logic [11:0] rgb;

    assign rgb = {red, green, blue};

    task automatic compare_pixel();
        for (int i = q_x.size() - 1; i >= 0; i--) begin
            if (q_x[i] == col && q_y[i] == line) begin
                if (rgb !== q_rgb[i]) begin
                    $display("error at %0t: pixel (%0d,%0d) shows %h, expected %h",
                             $time, col, line, rgb, q_rgb[i]);
                    value_errs++;
                end
                q_x.delete(i);
                q_y.delete(i);
                q_rgb.delete(i);
            end
        end
    endtask

    // One sample per pixel period
    task automatic sample_pixel();
        // A new frame opens on its first visible pixel
        if (lvbl_dly && !prev_v) begin
            in_frame = 1'b1;
            line     = 0;
            col      = 0;
        end
        if (lhbl_dly && lvbl_dly) begin
            if (in_frame) begin
                compare_pixel();
            end
            col++;
        end else if (rgb != 12'h000) begin
            $display("error at %0t: colour %h during blanking", $time, rgb);
            value_errs++;
        end
        if (prev_h && !lhbl_dly) begin
            if (in_frame && col != video_pkg::HVISIBLE) begin
                $display("error at %0t: line %0d had %0d visible pixels", $time, line, col);
                timing_errs++;
            end
            if (in_frame) begin
                line++;
            end
            col = 0;
        end
        if (prev_v && !lvbl_dly && in_frame) begin
            if (line != video_pkg::VVISIBLE) begin
                $display("error at %0t: frame had %0d visible lines", $time, line);
                timing_errs++;
            end
            in_frame = 1'b0;
        end
        prev_h = lhbl_dly;
        prev_v = lvbl_dly;
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value_errs  = 0;
            timing_errs = 0;
            miss_errs   = 0;
            col         = 0;
            line        = 0;
            prev_h      = 1'b0;
            prev_v      = 1'b0;
            in_frame    = 1'b0;
            pre_frame   = 1'b1;
        end else begin
            // Black and both blanks low until the first frame opens
            if (pre_frame) begin
                if (lvbl_dly) begin
                    pre_frame = 1'b0;
                end else if (rgb != 12'h000 || lhbl_dly) begin
                    $display("error at %0t: outputs not idle before the first frame",
                             $time);
                    timing_errs++;
                    pre_frame = 1'b0;
                end
            end
            if (exp_valid) begin
                q_x.push_back(int'(exp_x));
                q_y.push_back(int'(exp_y));
                q_rgb.push_back(exp_rgb);
            end
            if (exp_flush) begin
                foreach (q_x[i]) begin
                    $display("Expected pixel (%0d,%0d) was never shown", q_x[i], q_y[i]);
                end
                miss_errs += q_x.size();
                q_x.delete();
                q_y.delete();
                q_rgb.delete();
            end
            if (cen6) begin
                sample_pixel();
            end
        end
    end

endmodule

// File: dv/tb_video.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top for the character video block. Plays the stimulus file,
// models the graphics ROM with random latency and hands pixels to the checker.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_video;

    localparam int FRAME_CLKS = video_pkg::HTOTAL * video_pkg::VTOTAL * 2;

    logic clk, rst_n, cen6, flip, cpu_cen, vram_cs, pal_cs, wr_n;
    logic [1:0]            dseln;
    logic [9:0]            cpu_addr;
    logic [15:0]           cpu_dout;
    logic                  char_cs;
    video_pkg::rom_addr_t  char_addr;
    logic                  char_ok;
    video_pkg::rom_word_t  char_data;
    video_pkg::rgb4_t      red, green, blue;
    logic                  lhbl_dly, lvbl_dly;
    logic                  exp_valid, exp_flush;
    logic [8:0]            exp_x, exp_y;
    logic [11:0]           exp_rgb;
    int                    value_errs, timing_errs, miss_errs;
    logic [15:0]           rom_mult;
    logic                  rom_armed;
    int                    rom_delay, rom_cnt;
    int                    fd, n, fa, fb, fc;
    byte                   cmd;
    string                 line;
    logic                  run_bad;

    video_top i_dut (.*);

    video_checker i_chk (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cen6 <= ~cen6;
    end

    // Graphics ROM, answers after 1 to ROM_WAIT_MAX pixel periods
    always @(posedge clk) begin
        if (!rst_n || !char_cs) begin
            char_ok   <= 1'b0;
            rom_armed <= 1'b0;
        end else if (!rom_armed) begin
            rom_armed <= 1'b1;
            rom_delay <= int'($urandom % video_pkg::ROM_WAIT_MAX) + 1;
            rom_cnt   <= 0;
        end else if (!char_ok && cen6) begin
            if (rom_cnt + 1 >= rom_delay) begin
                char_ok   <= 1'b1;
                char_data <= video_pkg::rom_word_t'(32'(char_addr) * 32'(rom_mult));
            end
            rom_cnt <= rom_cnt + 1;
        end
    end

    task automatic cpu_write(input logic to_pal, input logic [9:0] addr,
                             input logic [15:0] data, input logic [1:0] sel);
        @(posedge clk);
        vram_cs  <= !to_pal;
        pal_cs   <= to_pal;
        wr_n     <= 1'b0;
        cpu_addr <= addr;
        cpu_dout <= data;
        dseln    <= sel;
        @(posedge clk);
        vram_cs <= 1'b0;
        pal_cs  <= 1'b0;
        wr_n    <= 1'b1;
        dseln   <= 2'b11;
    endtask

    // Counts ends of the visible frame
    task automatic wait_frames(input int count);
        int   guard;
        logic prev;
        logic seen;
        for (int f = 0; f < count && !run_bad; f++) begin
            guard = 0;
            seen  = 1'b0;
            prev  = lvbl_dly;
            while (!seen && guard < 2 * FRAME_CLKS) begin
                @(posedge clk);
                guard++;
                seen = prev && !lvbl_dly;
                prev = lvbl_dly;
            end
            if (!seen) begin
                $display("Timeout: no end of frame within %0d clocks", guard);
                run_bad = 1'b1;
            end
        end
    endtask

    task automatic pulse_expect(input int x, input int y, input int rgb);
        @(posedge clk);
        exp_valid <= 1'b1;
        exp_x     <= 9'(x);
        exp_y     <= 9'(y);
        exp_rgb   <= 12'(rgb);
        @(posedge clk);
        exp_valid <= 1'b0;
    endtask

    task automatic flush_expect();
        @(posedge clk);
        exp_flush <= 1'b1;
        @(posedge clk);
        exp_flush <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        rst_n     = 1'b0;
        cen6      = 1'b0;
        flip      = 1'b0;
        cpu_cen   = 1'b1;
        vram_cs   = 1'b0;
        pal_cs    = 1'b0;
        wr_n      = 1'b1;
        dseln     = 2'b11;
        cpu_addr  = '0;
        cpu_dout  = '0;
        char_ok   = 1'b0;
        char_data = '0;
        exp_valid = 1'b0;
        exp_flush = 1'b0;
        exp_x     = '0;
        exp_y     = '0;
        exp_rgb   = '0;
        rom_mult  = 16'h0001;
        rom_armed = 1'b0;
        rom_delay = 1;
        rom_cnt   = 0;
        run_bad   = 1'b0;
        void'($urandom(67));
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("dv/video_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/video_stimulus.txt");
            run_bad = 1'b1;
        end
        while (fd != 0 && !$feof(fd) && !run_bad) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                fa = 0;
                fb = 0;
                fc = 0;
                n = $sscanf(line, "%c %h %h %h", cmd, fa, fb, fc);
                case (cmd)
                    "V": cpu_write(1'b0, 10'(fa), 16'(fb), 2'(fc));
                    "P": cpu_write(1'b1, 10'(fa), 16'(fb), 2'b11);
                    "R": rom_mult = 16'(fa);
                    "F": begin
                        @(posedge clk);
                        flip <= fa[0];
                    end
                    "W": begin
                        wait_frames(fa);
                        flush_expect();
                    end
                    "E": pulse_expect(fa, fb, fc);
                    default: begin
                        $display("Unknown stimulus line: %s", line);
                        run_bad = 1'b1;
                    end
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        flush_expect();
        $display("Errors: value %0d, timing %0d, missing %0d, aborted %0d",
                 value_errs, timing_errs, miss_errs, run_bad);
        if (run_bad || value_errs + timing_errs + miss_errs != 0) begin
            $display(">>> FAIL");
        end else begin
            $display(">>> PASS");
        end
        $finish;
    end

endmodule

// File: dv/video_stimulus.txt
# cmd a b c, all fields hex: V addr data dseln | P index rgb | R rom_mult
# F flip | W frames | E x y rgb (expected colour at column x, line y)
R 123
P 0B ABC
P 0A 123
P 1E 5A3
P 1D 0F0
P 0E 321
P 0D 777
P 0C 9F1
V 000 0805 0
V 0AA 1C13 0
W 2
E 1 3 ABC
E 5 3 123
E 56 29 5A3
E 53 29 0F0
W 2
V 0AA 0C00 1
W 2
E 56 29 321
E 53 29 777
W 2
V 0AA 0021 2
W 2
E 51 29 321
E 54 29 9F1
E 1 3 ABC
W 2
F 1
W 2
E FE DC ABC
E FA DC 123
E AE B6 321
E AB B6 9F1
W 2
F 0
W 2
E 1 3 ABC
W 2

// File: src.f
logic/video_pkg.sv
logic/fetch_if.sv
logic/video_timing.sv
logic/char_fetch_fsm.sv
logic/char_layer.sv
logic/color_mix.sv
logic/video_top.sv
dv/video_checker.sv
dv/tb_video.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the character video testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f src.f --top-module tb_video \
    -o tb_video > build.log 2>&1 \
    && ./obj_dir/tb_video > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || exit 0
